//--- compile.f
src/ai_pkg.sv
src/ai_stream_if.sv
src/ai_feature_mem.sv
src/ai_cu_fsm.sv
src/ai_preprocess.sv
src/ai_conv3.sv
src/ai_postprocess.sv
src/ai_cu_top.sv
tests/tb_clk_gen.sv
tests/tb_ai_cu.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the accelerator testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_ai_cu -o tb_ai_cu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_ai_cu > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# only the pass line decides the result
if grep -q "^RESULT: PASS$" "$log"; then
  exit 0
fi
echo "pass line not found in $log"
exit 1

//--- tests/tb_ai_cu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ai_cu;

  logic clk;
  logic rst;
  logic host_we;
  ai_pkg::addr_t host_addr;
  ai_pkg::word_t host_wdata;
  ai_pkg::word_t host_rdata;
  logic start;
  ai_pkg::addr_t ifm_base;
  ai_pkg::len_t ifm_len;
  ai_pkg::addr_t ofm_base;
  ai_pkg::word_t cfg_zero_point;
  ai_pkg::word_t cfg_w0;
  ai_pkg::word_t cfg_w1;
  ai_pkg::word_t cfg_w2;
  logic [ai_pkg::shift_w-1:0] cfg_shift;
  logic busy;
  logic done;
  logic err;

  // expected memory contents
  ai_pkg::word_t shadow [ai_pkg::mem_depth];
  int seed = 32'h30f6;

  tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

  ai_cu_top dut_i (
    .clk(clk), .rst(rst), .host_we(host_we), .host_addr(host_addr),
    .host_wdata(host_wdata), .host_rdata(host_rdata), .start(start),
    .ifm_base(ifm_base), .ifm_len(ifm_len), .ofm_base(ofm_base),
    .cfg_zero_point(cfg_zero_point), .cfg_w0(cfg_w0), .cfg_w1(cfg_w1),
    .cfg_w2(cfg_w2), .cfg_shift(cfg_shift), .busy(busy), .done(done), .err(err)
  );

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input ai_pkg::word_t got,
                            input ai_pkg::word_t exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // reference model, input side
  function automatic ai_pkg::word_t sub_zero_point(input ai_pkg::word_t x,
                                                   input ai_pkg::word_t zp);
    int d;
    d = int'(x) - int'(zp);
    if (d > 127) d = 127;
    if (d < -128) d = -128;
    return ai_pkg::word_t'(d);
  endfunction

  // reference model, output side
  function automatic ai_pkg::word_t relu_shift_clamp(input int s, input int sh);
    if (s < 0) s = 0;
    s = s >>> sh;
    if (s > 127) s = 127;
    return ai_pkg::word_t'(s);
  endfunction

  task automatic host_write(input ai_pkg::addr_t a, input ai_pkg::word_t d);
    @(posedge clk);
    host_we <= 1'b1;
    host_addr <= a;
    host_wdata <= d;
    shadow[a] = d;
    @(posedge clk);
    host_we <= 1'b0;
  endtask

  // one-cycle read latency, sampled mid-cycle
  task automatic host_read(input ai_pkg::addr_t a, output ai_pkg::word_t d);
    @(posedge clk);
    host_addr <= a;
    @(posedge clk);
    @(negedge clk);
    d = host_rdata;
  endtask

  task automatic verify_memory();
    ai_pkg::word_t d;
    int a;
    for (a = 0; a < ai_pkg::mem_depth; a++) begin
      host_read(ai_pkg::addr_t'(a), d);
      check_word($sformatf("host_rdata[%0h]", a), d, shadow[ai_pkg::addr_t'(a)]);
    end
  endtask

  task automatic issue_start(input ai_pkg::addr_t ibase, input ai_pkg::len_t len,
                             input ai_pkg::addr_t obase, input ai_pkg::word_t zp,
                             input ai_pkg::word_t w0, input ai_pkg::word_t w1,
                             input ai_pkg::word_t w2, input logic [ai_pkg::shift_w-1:0] sh);
    @(posedge clk);
    start <= 1'b1;
    ifm_base <= ibase;
    ifm_len <= len;
    ofm_base <= obase;
    cfg_zero_point <= zp;
    cfg_w0 <= w0;
    cfg_w1 <= w1;
    cfg_w2 <= w2;
    cfg_shift <= sh;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic run_job(input ai_pkg::addr_t ibase, input ai_pkg::len_t len,
                         input ai_pkg::addr_t obase, input ai_pkg::word_t zp,
                         input ai_pkg::word_t w0, input ai_pkg::word_t w1,
                         input ai_pkg::word_t w2, input logic [ai_pkg::shift_w-1:0] sh);
    ai_pkg::word_t pre_q [$];
    ai_pkg::word_t exp_q [$];
    int i;
    int sum;
    int cycles;
    for (i = 0; i < int'(len); i++) begin
      pre_q.push_back(sub_zero_point(shadow[ai_pkg::addr_t'(int'(ibase) + i)], zp));
    end
    // three-tap window over the preprocessed words
    for (i = 0; i + 2 < int'(len); i++) begin
      sum = int'(w0) * int'(pre_q[i]) + int'(w1) * int'(pre_q[i+1])
          + int'(w2) * int'(pre_q[i+2]);
      exp_q.push_back(relu_shift_clamp(sum, int'(sh)));
    end
    issue_start(ibase, len, obase, zp, w0, w1, w2, sh);
    @(negedge clk);
    check_flag("busy", busy, 1'b1);
    check_flag("err", err, 1'b0);
    cycles = 0;
    while (done !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > int'(len) + 16) begin
        $display("done did not arrive within %0d cycles of start", cycles);
        abort_run();
      end
    end
    // busy drops in the same cycle as done
    check_flag("busy", busy, 1'b0);
    for (i = 0; i < exp_q.size(); i++) begin
      shadow[ai_pkg::addr_t'(int'(obase) + i)] = exp_q[i];
    end
    verify_memory();
  endtask

  task automatic write_readback_test();
    ai_pkg::word_t d;
    int a;
    for (a = 0; a < ai_pkg::mem_depth; a++) begin
      host_write(ai_pkg::addr_t'(a), ai_pkg::word_t'((a * 37) ^ (a >> 4)));
      host_read(ai_pkg::addr_t'(a), d);
      check_word($sformatf("host_rdata[%0h]", a), d, shadow[ai_pkg::addr_t'(a)]);
    end
  endtask

  task automatic known_job_test();
    ai_pkg::word_t known [8] = '{8'sd3, -8'sd1, 8'sd5, 8'sd10, -8'sd4, 8'sd7, 8'sd2, 8'sd0};
    int i;
    for (i = 0; i < 8; i++) begin
      host_write(ai_pkg::addr_t'(200 + i), known[i]);
    end
    run_job(8'd200, 9'd8, 8'd216, 8'sd0, 8'sd1, 8'sd2, 8'sd1, 4'd0);
  endtask

  // zero point 90 pushes low inputs under -128, high windows over 127
  task automatic saturation_test();
    ai_pkg::word_t words [10] = '{-8'sd100, -8'sd60, 8'sd120, 8'sd127, 8'sd100,
                                  -8'sd128, 8'sd50, 8'sd127, 8'sd127, 8'sd127};
    int i;
    for (i = 0; i < 10; i++) begin
      host_write(ai_pkg::addr_t'(64 + i), words[i]);
    end
    run_job(8'd64, 9'd10, 8'd80, 8'sd90, 8'sd3, 8'sd2, 8'sd1, 4'd0);
  endtask

  // inputs below 128, outputs above, twelve-word slots per job
  task automatic random_jobs_test();
    logic [31:0] r;
    logic [31:0] w;
    int j;
    int k;
    int len_i;
    ai_pkg::addr_t ibase;
    ai_pkg::addr_t obase;
    for (j = 0; j < 10; j++) begin
      r = $random(seed);
      len_i = 3 + int'(r[3:0]) % 10;
      ibase = ai_pkg::addr_t'(j * 12);
      obase = ai_pkg::addr_t'(128 + j * 12 + int'(r[4]));
      for (k = 0; k < len_i; k++) begin
        host_write(ai_pkg::addr_t'(int'(ibase) + k), ai_pkg::word_t'($random(seed)));
      end
      w = $random(seed);
      r = $random(seed);
      run_job(ibase, ai_pkg::len_t'(len_i), obase, w[31:24], w[7:0], w[15:8],
              w[23:16], r[3:0]);
    end
  endtask

  task automatic short_job_test();
    int i;
    issue_start(8'd0, 9'd2, 8'd250, 8'sd0, 8'sd1, 8'sd1, 8'sd1, 4'd0);
    @(negedge clk);
    check_flag("err", err, 1'b1);
    check_flag("busy", busy, 1'b0);
    for (i = 0; i < 8; i++) begin
      @(negedge clk);
      check_flag("err", err, 1'b0);
      check_flag("busy", busy, 1'b0);
      check_flag("done", done, 1'b0);
    end
    verify_memory();
    // unit still accepts a normal job afterwards
    run_job(8'd0, 9'd5, 8'd250, 8'sd4, 8'sd2, -8'sd1, 8'sd3, 4'd1);
  endtask

  initial begin : main_seq
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    start = 1'b0;
    ifm_base = '0;
    ifm_len = '0;
    ofm_base = '0;
    cfg_zero_point = '0;
    cfg_w0 = '0;
    cfg_w1 = '0;
    cfg_w2 = '0;
    cfg_shift = '0;
    wait (rst === 1'b0);
    @(negedge clk);
    // idle state out of reset
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    check_flag("err", err, 1'b0);
    check_flag("wb_we", dut_i.wb_we, 1'b0);
    write_readback_test();
    known_job_test();
    saturation_test();
    random_jobs_test();
    short_job_test();
    $display("RESULT: PASS");
    $finish;
  end

  // fill pass, fourteen memory sweeps and job time, with margin of four
  initial begin : watchdog
    int limit;
    limit = 4 * (4 * ai_pkg::mem_depth + 14 * (2 * ai_pkg::mem_depth + 64)) + 16;
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles before the tests finished", limit);
    abort_run();
  end

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held for the first 16 cycles
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- src/ai_cu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ai_cu_top (
  input  logic          clk,
  input  logic          rst,
  input  logic          host_we,
  input  ai_pkg::addr_t host_addr,
  input  ai_pkg::word_t host_wdata,
  output ai_pkg::word_t host_rdata,
  input  logic          start,
  input  ai_pkg::addr_t ifm_base,
  input  ai_pkg::len_t  ifm_len,
  input  ai_pkg::addr_t ofm_base,
  input  ai_pkg::word_t cfg_zero_point,
  input  ai_pkg::word_t cfg_w0,
  input  ai_pkg::word_t cfg_w1,
  input  ai_pkg::word_t cfg_w2,
  input  logic [ai_pkg::shift_w-1:0] cfg_shift,
  output logic          busy,
  output logic          done,
  output logic          err
);

  ai_pkg::cfg_t cfg_in;
  ai_pkg::cfg_t cfg;
  ai_pkg::addr_t ofm_base_q;
  ai_pkg::addr_t fetch_addr;
  logic fetch_rd;
  logic wb_we;
  ai_pkg::addr_t wb_addr;
  ai_pkg::word_t wb_data;
  logic wb_last;
  logic mem_we;
  ai_pkg::addr_t mem_waddr;
  ai_pkg::word_t mem_wdata;

  ai_stream_if #(.payload_t(ai_pkg::word_t)) fetch_s ();
  ai_stream_if #(.payload_t(ai_pkg::word_t)) pre_s ();
  ai_stream_if #(.payload_t(ai_pkg::acc_t)) conv_s ();

  assign cfg_in = '{cfg_zero_point, cfg_w0, cfg_w1, cfg_w2, cfg_shift};

  // writeback owns the write port while a job runs
  assign mem_we = busy ? wb_we : host_we;
  assign mem_waddr = busy ? wb_addr : host_addr;
  assign mem_wdata = busy ? wb_data : host_wdata;

  ai_feature_mem mem_i (
    .clk(clk), .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata),
    .fetch_addr(fetch_addr), .fetch_rd(fetch_rd), .fetch_data(fetch_s.data),
    .host_addr(host_addr), .host_rdata(host_rdata)
  );

  ai_cu_fsm cu_i (
    .clk(clk), .rst(rst), .start(start), .ifm_base(ifm_base), .ifm_len(ifm_len),
    .ofm_base(ofm_base), .cfg_in(cfg_in), .wb_last(wb_last), .fetch_addr(fetch_addr),
    .fetch_rd(fetch_rd), .fetch_s(fetch_s), .cfg(cfg), .ofm_base_q(ofm_base_q),
    .busy(busy), .done(done), .err(err)
  );

  ai_preprocess pre_i (.clk(clk), .rst(rst), .cfg(cfg), .in_s(fetch_s), .out_s(pre_s));

  ai_conv3 conv_i (.clk(clk), .rst(rst), .cfg(cfg), .in_s(pre_s), .out_s(conv_s));

  ai_postprocess post_i (
    .clk(clk), .rst(rst), .cfg(cfg), .ofm_base(ofm_base_q), .in_s(conv_s),
    .wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data), .wb_last(wb_last)
  );

  // host writes during a job would be lost
  a_no_host_write_busy: assert property (@(posedge clk) disable iff (rst)
    host_we |-> !busy);

endmodule

`default_nettype wire

//--- src/ai_postprocess.sv
`timescale 1ns/1ps
`default_nettype none

module ai_postprocess (
  input  logic          clk,
  input  logic          rst,
  input  ai_pkg::cfg_t  cfg,
  input  ai_pkg::addr_t ofm_base,
  ai_stream_if.sink     in_s,
  output logic          wb_we,
  output ai_pkg::addr_t wb_addr,
  output ai_pkg::word_t wb_data,
  output logic          wb_last
);

  ai_pkg::acc_t relu;
  ai_pkg::acc_t shifted;
  ai_pkg::word_t clamped;
  // next output slot within the job
  ai_pkg::addr_t out_idx;
  ai_pkg::addr_t cur_idx;

  // negative sums go to zero
  assign relu = in_s.data[ai_pkg::acc_w-1] ? '0 : in_s.data;
  assign shifted = relu >>> cfg.shift;
  // only the upper bound can be hit after relu
  assign clamped = (shifted > ai_pkg::acc_t'(127)) ? 8'sd127 : ai_pkg::word_t'(shifted);

  assign cur_idx = in_s.first ? '0 : out_idx;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_we <= 1'b0;
      wb_last <= 1'b0;
      out_idx <= '0;
    end else begin
      wb_we <= in_s.valid;
      // marks the final write of the job
      wb_last <= in_s.valid && in_s.last;
      if (in_s.valid) begin
        out_idx <= cur_idx + ai_pkg::addr_t'(1);
      end
    end
  end

  // write address and data
  always_ff @(posedge clk) begin
    wb_addr <= ofm_base + cur_idx;
    wb_data <= clamped;
  end

endmodule

`default_nettype wire

//--- src/ai_conv3.sv
`timescale 1ns/1ps
`default_nettype none

module ai_conv3 (
  input  logic         clk,
  input  logic         rst,
  input  ai_pkg::cfg_t cfg,
  ai_stream_if.sink    in_s,
  ai_stream_if.source  out_s
);

  // window, oldest and middle word
  ai_pkg::word_t win_old;
  ai_pkg::word_t win_mid;
  // words seen this job, saturates at 3
  logic [1:0] fill;
  logic [1:0] fill_eff;
  logic emit;
  logic in_job;
  ai_pkg::acc_t sum;

  // first restarts the window
  assign fill_eff = in_s.first ? 2'd0 : fill;
  // two older words already in the window
  assign emit = in_s.valid && (fill_eff >= 2'd2);

  assign sum = ai_pkg::acc_t'(cfg.w0) * ai_pkg::acc_t'(win_old)
             + ai_pkg::acc_t'(cfg.w1) * ai_pkg::acc_t'(win_mid)
             + ai_pkg::acc_t'(cfg.w2) * ai_pkg::acc_t'(in_s.data);

  always_ff @(posedge clk) begin
    if (rst) begin
      fill <= 2'd0;
      in_job <= 1'b0;
      out_s.valid <= 1'b0;
      out_s.first <= 1'b0;
      out_s.last <= 1'b0;
    end else begin
      out_s.valid <= emit;
      // first output is the third word of the job
      out_s.first <= emit && (fill_eff == 2'd2);
      out_s.last <= emit && in_s.last;
      if (in_s.valid) begin
        fill <= (fill_eff == 2'd3) ? 2'd3 : fill_eff + 2'd1;
        in_job <= !in_s.last;
      end
    end
  end

  // window shift and sum register
  always_ff @(posedge clk) begin
    if (in_s.valid) begin
      win_old <= win_mid;
      win_mid <= in_s.data;
    end
    out_s.data <= sum;
  end

  // a new job only starts after the previous one saw its last word
  a_first_after_last: assert property (@(posedge clk) disable iff (rst)
    in_s.valid && in_s.first |-> !in_job);

endmodule

`default_nettype wire

//--- src/ai_preprocess.sv
`timescale 1ns/1ps
`default_nettype none

module ai_preprocess (
  input  logic         clk,
  input  logic         rst,
  input  ai_pkg::cfg_t cfg,
  ai_stream_if.sink    in_s,
  ai_stream_if.source  out_s
);

  // one extra bit holds the full difference
  logic signed [8:0] diff;
  ai_pkg::word_t sat;

  assign diff = 9'(in_s.data) - 9'(cfg.zero_point);

  // clamp to the word range
  always_comb begin
    if (diff > 9'sd127) begin
      sat = 8'sd127;
    end else if (diff < -9'sd128) begin
      sat = -8'sd128;
    end else begin
      sat = diff[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_s.valid <= 1'b0;
      out_s.first <= 1'b0;
      out_s.last <= 1'b0;
    end else begin
      out_s.valid <= in_s.valid;
      out_s.first <= in_s.valid && in_s.first;
      out_s.last <= in_s.valid && in_s.last;
    end
  end

  // payload follows valid
  always_ff @(posedge clk) begin
    out_s.data <= sat;
  end

endmodule

`default_nettype wire

//--- src/ai_cu_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ai_cu_fsm (
  input  logic          clk,
  input  logic          rst,
  input  logic          start,
  input  ai_pkg::addr_t ifm_base,
  input  ai_pkg::len_t  ifm_len,
  input  ai_pkg::addr_t ofm_base,
  input  ai_pkg::cfg_t  cfg_in,
  input  logic          wb_last,
  output ai_pkg::addr_t fetch_addr,
  output logic          fetch_rd,
  ai_stream_if.source   fetch_s,
  output ai_pkg::cfg_t  cfg,
  output ai_pkg::addr_t ofm_base_q,
  output logic          busy,
  output logic          done,
  output logic          err
);

  typedef enum logic [1:0] {st_idle, st_fetch, st_drain} state_t;

  state_t state;
  ai_pkg::addr_t rd_addr;
  ai_pkg::len_t rd_cnt;
  ai_pkg::len_t last_idx;
  logic short_job;
  logic accept;

  // a window of three needs at least three words
  assign short_job = ifm_len < ai_pkg::len_t'(3);
  // start only counts while idle
  assign accept = (state == st_idle) && start;

  assign fetch_rd = state == st_fetch;
  assign fetch_addr = rd_addr;
  assign busy = state != st_idle;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      err <= 1'b0;
      done <= 1'b0;
      fetch_s.valid <= 1'b0;
      fetch_s.first <= 1'b0;
      fetch_s.last <= 1'b0;
    end else begin
      err <= accept && short_job;
      done <= 1'b0;
      // flags delayed one cycle to match the memory read
      fetch_s.valid <= fetch_rd;
      fetch_s.first <= fetch_rd && (rd_cnt == '0);
      fetch_s.last <= fetch_rd && (rd_cnt == last_idx);
      case (state)
        st_idle: begin
          if (accept && !short_job) begin
            state <= st_fetch;
          end
        end
        // last read issued, wait for the pipeline
        st_fetch: begin
          if (rd_cnt == last_idx) begin
            state <= st_drain;
          end
        end
        st_drain: begin
          if (wb_last) begin
            state <= st_idle;
            done <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // job settings and read pointer
  always_ff @(posedge clk) begin
    if (accept) begin
      cfg <= cfg_in;
      ofm_base_q <= ofm_base;
      rd_addr <= ifm_base;
      rd_cnt <= '0;
      last_idx <= ifm_len - ai_pkg::len_t'(1);
    end else if (fetch_rd) begin
      rd_addr <= rd_addr + ai_pkg::addr_t'(1);
      rd_cnt <= rd_cnt + ai_pkg::len_t'(1);
    end
  end

  // reads never run past the last word of the job
  a_fetch_burst: assert property (@(posedge clk) disable iff (rst)
    fetch_rd |-> rd_cnt <= last_idx);

endmodule

`default_nettype wire

//--- src/ai_feature_mem.sv
`timescale 1ns/1ps
`default_nettype none

module ai_feature_mem (
  input  logic          clk,
  input  logic          we,
  input  ai_pkg::addr_t waddr,
  input  ai_pkg::word_t wdata,
  input  ai_pkg::addr_t fetch_addr,
  input  logic          fetch_rd,
  output ai_pkg::word_t fetch_data,
  input  ai_pkg::addr_t host_addr,
  output ai_pkg::word_t host_rdata
);

  // feature storage, shared by input and output maps
  ai_pkg::word_t mem [ai_pkg::mem_depth];

  // single write port, writeback or host
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // fetch read, only updates on a request
  always_ff @(posedge clk) begin
    if (fetch_rd) begin
      fetch_data <= mem[fetch_addr];
    end
  end

  // host read, every cycle
  always_ff @(posedge clk) begin
    host_rdata <= mem[host_addr];
  end

endmodule

`default_nettype wire

//--- src/ai_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// one word per valid strobe, no back-pressure
interface ai_stream_if #(
  parameter type payload_t = ai_pkg::word_t
) ();

  logic valid;
  // job boundary markers
  logic first;
  logic last;
  payload_t data;

  modport source (output valid, output first, output last, output data);

  modport sink (input valid, input first, input last, input data);

endinterface

`default_nettype wire

//--- src/ai_pkg.sv
`default_nettype none

package ai_pkg;

  // feature memory geometry
  localparam int addr_w = 8;
  localparam int mem_depth = 256;

  // job length, wide enough for a full memory
  localparam int len_w = 9;

  // convolution sum, room for three 8x8 products
  localparam int acc_w = 20;

  // postprocess shift amount
  localparam int shift_w = 4;

  typedef logic signed [7:0] word_t;
  typedef logic signed [acc_w-1:0] acc_t;
  typedef logic [addr_w-1:0] addr_t;
  typedef logic [len_w-1:0] len_t;

  // per-job settings, latched at start
  typedef struct packed {
    word_t zero_point;
    word_t w0;
    word_t w1;
    word_t w2;
    logic [shift_w-1:0] shift;
  } cfg_t;

endpackage

`default_nettype wire
